//--- source/mpu_pkg.sv
// Shared definitions for the data-side MPU
// Physical addresses are 32 bits wide, data buses are 32 bits wide
// The PMA region table is fixed here and cannot be changed at run time
// pmpaddr words hold address bits [33:2], so only the low 4 GiB are reachable
// Unmatched addresses fall back to non-bufferable, non-cacheable I/O
package mpu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned PMP_N  = 4;

  ////////////////////////////////////////////////////////////
  // PMA region table
  ////////////////////////////////////////////////////////////

  // Debug module, only special for debug-mode requests
  localparam logic [ADDR_W-1:0] DM_START = 32'hF000_0000;
  localparam logic [ADDR_W-1:0] DM_END   = 32'hF000_3FFF;

  // Main memory, cacheable and bufferable
  localparam logic [ADDR_W-1:0] PMA_MAIN_START = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] PMA_MAIN_END   = 32'h0FFF_FFFF;

  // Bufferable I/O
  localparam logic [ADDR_W-1:0] PMA_IO_START = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] PMA_IO_END   = 32'h1FFF_FFFF;

  ////////////////////////////////////////////////////////////
  // PMP configuration byte layout
  ////////////////////////////////////////////////////////////

  localparam int unsigned CFG_R    = 0;
  localparam int unsigned CFG_W    = 1;
  localparam int unsigned CFG_X    = 2;
  // Address-matching mode field
  localparam int unsigned CFG_A_LO = 3;
  localparam int unsigned CFG_A_HI = 4;
  localparam int unsigned CFG_L    = 7;

  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  typedef enum logic {
    PMP_ACC_READ  = 1'b0,
    PMP_ACC_WRITE = 1'b1
  } pmp_acc_e;

  // Privilege encoding as in the mstatus MPP field
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  ////////////////////////////////////////////////////////////
  // Response status and gate FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    MPU_OK           = 3'd0,
    MPU_RD_PMA_FAULT = 3'd1,
    MPU_WR_PMA_FAULT = 3'd2,
    MPU_RD_PMP_FAULT = 3'd3,
    MPU_WR_PMP_FAULT = 3'd4
  } mpu_status_e;

  typedef enum logic [1:0] {
    MPU_IDLE = 2'd0,
    MPU_WAIT = 2'd1,
    MPU_RESP = 2'd2
  } mpu_state_e;

endpackage

//--- source/mpu_req_if.sv
// Request fields read by both checkers and by the gate
// All fields are levels, held stable by the core while ready is low
`timescale 1ns/1ps

interface mpu_req_if import mpu_pkg::*; ();

  // Byte address of the access
  logic [ADDR_W-1:0] addr;
  // High for stores
  logic              we;
  // Request issued in debug mode
  logic              dbg;
  // Part of a split misaligned access
  logic              misaligned;
  // Stack push or pop
  logic              pushpop;

  // Driven from the core-side ports
  modport src (
    output addr, we, dbg, misaligned, pushpop
  );

  // Read-only view for the checkers and the gate
  modport chk (
    input addr, we, dbg, misaligned, pushpop
  );

endinterface

//--- source/pma_check.sv
// Physical memory attribute lookup against the fixed region table
// Purely combinational, zero latency
// Misaligned and push/pop accesses are legal in main memory only
// Debug-mode requests to the debug module see main memory without attributes
`timescale 1ns/1ps

module pma_check import mpu_pkg::*; (
  mpu_req_if.chk req_i,
  output logic   pma_err_o,
  output logic   pma_bufferable_o,
  output logic   pma_cacheable_o
);

  logic in_dm;
  logic in_main;
  logic in_io;
  logic region_main;
  logic region_buf;
  logic region_cache;

  // Debug override needs the dbg flag as well as the address
  assign in_dm = req_i.dbg &&
                 (req_i.addr >= DM_START) && (req_i.addr <= DM_END);

  assign in_main = (req_i.addr >= PMA_MAIN_START) && (req_i.addr <= PMA_MAIN_END);
  assign in_io   = (req_i.addr >= PMA_IO_START) && (req_i.addr <= PMA_IO_END);

  ////////////////////////////////////////////////////////////
  // Region selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Default region is plain I/O
    region_main  = 1'b0;
    region_buf   = 1'b0;
    region_cache = 1'b0;

    if (in_dm) begin
      // Debug module behaves as main memory, no attributes
      region_main = 1'b1;
    end else if (in_main) begin
      region_main  = 1'b1;
      region_buf   = 1'b1;
      region_cache = 1'b1;
    end else if (in_io) begin
      // Posted writes allowed, never cached
      region_buf = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Verdict
  ////////////////////////////////////////////////////////////

  // Split and stack accesses only where memory semantics are guaranteed
  assign pma_err_o = (req_i.misaligned || req_i.pushpop) && !region_main;

  // Attributes go to the bus as memtype bits
  assign pma_bufferable_o = region_buf;
  assign pma_cacheable_o  = region_cache;

endmodule

//--- source/pmp_check.sv
// Four-entry physical memory protection check for loads and stores
// Purely combinational, zero latency
// pmpaddr entries hold address bits [33:2], granularity is one word
// Configuration arrives as plain levels, no CSR storage or lock logic on writes
// Matching follows the privileged spec, the lowest matching entry decides
// Debug-mode accesses to the debug module always pass
`timescale 1ns/1ps

module pmp_check import mpu_pkg::*; (
  mpu_req_if.chk                     req_i,
  input  logic [PMP_N-1:0][7:0]       csr_pmpcfg_i,
  input  logic [PMP_N-1:0][ADDR_W-1:0] csr_pmpaddr_i,
  input  priv_e                      priv_lvl_i,
  output logic                       pmp_err_o
);

  pmp_acc_e          acc;
  logic [ADDR_W-1:0] word_addr;
  logic [PMP_N-1:0]  entry_match;
  logic [PMP_N-1:0]  entry_perm;
  logic [PMP_N-1:0]  entry_bypass;
  logic              dm_access;
  logic              allowed;

  // Data side only knows reads and writes
  assign acc = req_i.we ? PMP_ACC_WRITE : PMP_ACC_READ;

  // Word address in pmpaddr units
  assign word_addr = {2'b00, req_i.addr[ADDR_W-1:2]};

  assign dm_access = req_i.dbg &&
                     (req_i.addr >= DM_START) && (req_i.addr <= DM_END);

  ////////////////////////////////////////////////////////////
  // Per-entry match and permission
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < PMP_N; i++) begin : g_entry
    pmp_mode_e         mode;
    logic [ADDR_W-1:0] lower;
    logic [ADDR_W-1:0] napot_mask;

    assign mode = pmp_mode_e'(csr_pmpcfg_i[i][CFG_A_HI:CFG_A_LO]);

    // TOR lower bound is the previous entry, zero for the first one
    if (i == 0) begin : g_first
      assign lower = '0;
    end else begin : g_next
      assign lower = csr_pmpaddr_i[i-1];
    end

    // Trailing ones plus the first zero are don't-care bits
    assign napot_mask = ~(csr_pmpaddr_i[i] ^ (csr_pmpaddr_i[i] + 1'b1));

    always_comb begin
      case (mode)
        PMP_MODE_TOR: begin
          entry_match[i] = (word_addr >= lower) && (word_addr < csr_pmpaddr_i[i]);
        end
        PMP_MODE_NA4: begin
          entry_match[i] = (word_addr == csr_pmpaddr_i[i]);
        end
        PMP_MODE_NAPOT: begin
          entry_match[i] = ((word_addr & napot_mask) ==
                            (csr_pmpaddr_i[i] & napot_mask));
        end
        default: begin
          entry_match[i] = 1'b0;
        end
      endcase
    end

    // R or W bit depending on direction
    assign entry_perm[i] = (acc == PMP_ACC_WRITE) ? csr_pmpcfg_i[i][CFG_W] :
                                                    csr_pmpcfg_i[i][CFG_R];

    // Unlocked entries do not restrict M mode
    assign entry_bypass[i] = (priv_lvl_i == PRIV_M) && !csr_pmpcfg_i[i][CFG_L];
  end

  ////////////////////////////////////////////////////////////
  // Priority resolution
  ////////////////////////////////////////////////////////////

  always_comb begin
    // No match: M mode allowed, U mode denied
    allowed = (priv_lvl_i == PRIV_M);
    // Walk from the top so the lowest matching entry is applied last
    for (int i = PMP_N - 1; i >= 0; i--) begin
      if (entry_match[i]) begin
        allowed = entry_bypass[i] || entry_perm[i];
      end
    end
  end

  assign pmp_err_o = !(allowed || dm_access);

endmodule

//--- source/mpu_gate.sv
// Combines the PMA and PMP verdicts and controls the core/bus handshake
// Clean requests pass combinationally, ready follows the bus ready
// A faulting request is accepted at once and never reaches the bus
// The fault response waits until it is the only outstanding transaction
// The core must always accept a response strobe
`timescale 1ns/1ps

module mpu_gate import mpu_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  mpu_req_if.chk              req_i,
  input  logic                pma_err_i,
  input  logic                pmp_err_i,
  input  logic                pma_bufferable_i,
  input  logic                pma_cacheable_i,
  // Core request side
  input  logic                core_trans_valid_i,
  output logic                core_trans_ready_o,
  input  logic                core_one_txn_pend_i,
  input  logic [DATA_W-1:0]   core_wdata_i,
  input  logic [DATA_W/8-1:0] core_be_i,
  // Bus request side
  output logic                bus_trans_valid_o,
  input  logic                bus_trans_ready_i,
  output logic [ADDR_W-1:0]   bus_addr_o,
  output logic                bus_we_o,
  output logic [DATA_W-1:0]   bus_wdata_o,
  output logic [DATA_W/8-1:0] bus_be_o,
  output logic [1:0]          bus_memtype_o,
  // Bus response side
  input  logic                bus_resp_valid_i,
  input  logic [DATA_W-1:0]   bus_resp_rdata_i,
  input  logic                bus_resp_err_i,
  // Core response side
  output logic                core_resp_valid_o,
  output logic [DATA_W-1:0]   core_resp_rdata_o,
  output logic                core_resp_err_o,
  output mpu_status_e         core_resp_status_o
);

  mpu_state_e  state_q;
  mpu_state_e  state_d;
  mpu_status_e status_q;
  mpu_status_e fault_status;
  logic        fault;
  logic        block;
  logic        err_ready;
  logic        err_valid;

  assign fault = pma_err_i || pmp_err_i;

  // PMA wins over PMP, direction from we
  always_comb begin
    if (pma_err_i) begin
      fault_status = req_i.we ? MPU_WR_PMA_FAULT : MPU_RD_PMA_FAULT;
    end else begin
      fault_status = req_i.we ? MPU_WR_PMP_FAULT : MPU_RD_PMP_FAULT;
    end
  end

  ////////////////////////////////////////////////////////////
  // Consume FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    block     = 1'b0;
    err_ready = 1'b0;
    err_valid = 1'b0;

    case (state_q)
      MPU_IDLE: begin
        if (core_trans_valid_i && fault) begin
          // Take the request off the core, keep it off the bus
          block     = 1'b1;
          err_ready = 1'b1;
          state_d   = core_one_txn_pend_i ? MPU_RESP : MPU_WAIT;
        end
      end
      MPU_WAIT: begin
        // Hold off new traffic until older transactions drain
        block = 1'b1;
        if (core_one_txn_pend_i) begin
          state_d = MPU_RESP;
        end
      end
      MPU_RESP: begin
        block     = 1'b1;
        err_valid = 1'b1;
        // Response is always taken
        state_d   = MPU_IDLE;
      end
      default: begin
        state_d = MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Fault kind captured at acceptance, read only in MPU_RESP
  always_ff @(posedge clk) begin
    if (err_ready) begin
      status_q <= fault_status;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request forwarding
  ////////////////////////////////////////////////////////////

  assign bus_trans_valid_o  = core_trans_valid_i && !block;
  assign core_trans_ready_o = (bus_trans_ready_i && !block) || err_ready;

  assign bus_addr_o  = req_i.addr;
  assign bus_we_o    = req_i.we;
  assign bus_wdata_o = core_wdata_i;
  assign bus_be_o    = core_be_i;
  // Bit 0 bufferable, bit 1 cacheable
  assign bus_memtype_o = {pma_cacheable_i, pma_bufferable_i};

  ////////////////////////////////////////////////////////////
  // Response merging
  ////////////////////////////////////////////////////////////

  // Bus and fault responses never coincide, the faulting one is the last in flight
  assign core_resp_valid_o  = bus_resp_valid_i || err_valid;
  assign core_resp_rdata_o  = bus_resp_rdata_i;
  assign core_resp_err_o    = bus_resp_valid_i && bus_resp_err_i;
  assign core_resp_status_o = err_valid ? status_q : MPU_OK;

endmodule

//--- source/lsu_mpu.sv
// Data-side MPU top level with plain core, bus and CSR ports
// PMA and PMP checks run in parallel on the same request
// PMP configuration is taken as static levels from outside
`timescale 1ns/1ps

module lsu_mpu import mpu_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  // Core request
  input  logic                         core_trans_valid_i,
  output logic                         core_trans_ready_o,
  input  logic [ADDR_W-1:0]            core_addr_i,
  input  logic                         core_we_i,
  input  logic                         core_dbg_i,
  input  logic                         core_misaligned_i,
  input  logic                         core_pushpop_i,
  input  logic [DATA_W-1:0]            core_wdata_i,
  input  logic [DATA_W/8-1:0]          core_be_i,
  input  logic                         core_one_txn_pend_i,
  // PMP setup and privilege
  input  logic [PMP_N-1:0][7:0]        csr_pmpcfg_i,
  input  logic [PMP_N-1:0][ADDR_W-1:0] csr_pmpaddr_i,
  input  priv_e                        priv_lvl_i,
  // Bus request
  output logic                         bus_trans_valid_o,
  input  logic                         bus_trans_ready_i,
  output logic [ADDR_W-1:0]            bus_addr_o,
  output logic                         bus_we_o,
  output logic [DATA_W-1:0]            bus_wdata_o,
  output logic [DATA_W/8-1:0]          bus_be_o,
  output logic [1:0]                   bus_memtype_o,
  // Bus response
  input  logic                         bus_resp_valid_i,
  input  logic [DATA_W-1:0]            bus_resp_rdata_i,
  input  logic                         bus_resp_err_i,
  // Core response
  output logic                         core_resp_valid_o,
  output logic [DATA_W-1:0]            core_resp_rdata_o,
  output logic                         core_resp_err_o,
  output mpu_status_e                  core_resp_status_o
);

  logic pma_err;
  logic pma_bufferable;
  logic pma_cacheable;
  logic pmp_err;

  // Request bundle shared by checkers and gate
  mpu_req_if req_bus ();

  assign req_bus.addr       = core_addr_i;
  assign req_bus.we         = core_we_i;
  assign req_bus.dbg        = core_dbg_i;
  assign req_bus.misaligned = core_misaligned_i;
  assign req_bus.pushpop    = core_pushpop_i;

  pma_check u_pma (
    .req_i            (req_bus.chk),
    .pma_err_o        (pma_err),
    .pma_bufferable_o (pma_bufferable),
    .pma_cacheable_o  (pma_cacheable)
  );

  pmp_check u_pmp (
    .req_i         (req_bus.chk),
    .csr_pmpcfg_i  (csr_pmpcfg_i),
    .csr_pmpaddr_i (csr_pmpaddr_i),
    .priv_lvl_i    (priv_lvl_i),
    .pmp_err_o     (pmp_err)
  );

  mpu_gate u_gate (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_bus.chk),
    .pma_err_i           (pma_err),
    .pmp_err_i           (pmp_err),
    .pma_bufferable_i    (pma_bufferable),
    .pma_cacheable_i     (pma_cacheable),
    .core_trans_valid_i  (core_trans_valid_i),
    .core_trans_ready_o  (core_trans_ready_o),
    .core_one_txn_pend_i (core_one_txn_pend_i),
    .core_wdata_i        (core_wdata_i),
    .core_be_i           (core_be_i),
    .bus_trans_valid_o   (bus_trans_valid_o),
    .bus_trans_ready_i   (bus_trans_ready_i),
    .bus_addr_o          (bus_addr_o),
    .bus_we_o            (bus_we_o),
    .bus_wdata_o         (bus_wdata_o),
    .bus_be_o            (bus_be_o),
    .bus_memtype_o       (bus_memtype_o),
    .bus_resp_valid_i    (bus_resp_valid_i),
    .bus_resp_rdata_i    (bus_resp_rdata_i),
    .bus_resp_err_i      (bus_resp_err_i),
    .core_resp_valid_o   (core_resp_valid_o),
    .core_resp_rdata_o   (core_resp_rdata_o),
    .core_resp_err_o     (core_resp_err_o),
    .core_resp_status_o  (core_resp_status_o)
  );

endmodule

//--- bench/tb_clk_gen.sv
// Free-running clock and power-on reset for the testbench
// Reset is released on a falling edge, away from the sampling edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Low for RST_CYCLES full periods
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- bench/tb_lsu_mpu.sv
// Random-stimulus testbench for the data-side MPU
// PMP setup is static, four entries cover NA4, TOR and two NAPOT regions
// Bus model answers in order after 1 to 4 cycles, one response per cycle
// Inputs change on the falling edge, checks sample on the rising edge
`timescale 1ns/1ps

module tb_lsu_mpu import mpu_pkg::*; ();

  localparam int N_REQ       = 400;
  localparam int CLK_NS      = 8;
  localparam int RST_CYC     = 8;
  localparam int WATCHDOG_NS = (N_REQ * 12 + RST_CYC) * CLK_NS;

  // e0 NA4 0x1000 R locked, e1 TOR up to 0x40_0000 R, e2 NAPOT 64K I/O R locked,
  // e3 NAPOT 256M main RW
  localparam logic [PMP_N-1:0][7:0]        PMP_CFG  = {8'h1B, 8'h99, 8'h09, 8'h91};
  localparam logic [PMP_N-1:0][ADDR_W-1:0] PMP_ADDR = {32'h01FF_FFFF, 32'h0400_1FFF,
                                                       32'h0010_0000, 32'h0000_0400};

  logic clk;
  logic rst_n;
  logic core_trans_valid_i, core_trans_ready_o, core_we_i, core_dbg_i;
  logic core_misaligned_i, core_pushpop_i, core_one_txn_pend_i;
  logic [ADDR_W-1:0] core_addr_i;
  logic [DATA_W-1:0] core_wdata_i;
  logic [DATA_W/8-1:0] core_be_i;
  logic [PMP_N-1:0][7:0] csr_pmpcfg_i;
  logic [PMP_N-1:0][ADDR_W-1:0] csr_pmpaddr_i;
  priv_e priv_lvl_i;
  logic bus_trans_valid_o, bus_trans_ready_i, bus_we_o;
  logic [ADDR_W-1:0] bus_addr_o;
  logic [DATA_W-1:0] bus_wdata_o;
  logic [DATA_W/8-1:0] bus_be_o;
  logic [1:0] bus_memtype_o;
  logic bus_resp_valid_i, bus_resp_err_i;
  logic [DATA_W-1:0] bus_resp_rdata_i;
  logic core_resp_valid_o, core_resp_err_o;
  logic [DATA_W-1:0] core_resp_rdata_o;
  mpu_status_e core_resp_status_o;

  // Reference verdict for the request on the core port
  logic [2:0]  pma_exp;
  logic        pmp_exp;
  logic        exp_fault;
  mpu_status_e exp_status;
  // Expected gate state and latched fault kind
  mpu_state_e  m_state;
  mpu_status_e m_status;

  logic [31:0] lfsr_q;
  int          due_q[$];
  int          cyc, issued, err_cnt, fault_cnt, resp_cnt;
  int          core_acc_cnt, clean_acc_cnt, bus_acc_cnt;
  bit          taken;

  tb_clk_gen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(RST_CYC)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

  lsu_mpu uut (.*);

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  // Taps 32,22,2,1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // Returns {error, cacheable, bufferable}
  function automatic logic [2:0] pma_expect(input logic [31:0] a, input logic dbg, mis, pp);
    logic odd;
    odd = mis || pp;
    if (dbg && a >= DM_START && a <= DM_END) return 3'b000;
    if (a >= PMA_MAIN_START && a <= PMA_MAIN_END) return 3'b011;
    if (a >= PMA_IO_START && a <= PMA_IO_END) return {odd, 2'b01};
    return {odd, 2'b00};
  endfunction

  function automatic logic pmp_denies(input logic [31:0] a, input logic we, dbg,
                                      input priv_e priv);
    logic [33:0] ba;
    logic [33:0] lo;
    logic [1:0]  mode;
    logic        hit;
    int          k;
    ba = {2'b00, a};
    if (dbg && a >= DM_START && a <= DM_END) return 1'b0;
    for (int i = 0; i < PMP_N; i++) begin
      mode = PMP_CFG[i][4:3];
      hit  = 1'b0;
      lo   = '0;
      if (i > 0) lo = {PMP_ADDR[i-1], 2'b00};
      if (mode == 2'b01) hit = (ba >= lo) && (ba < {PMP_ADDR[i], 2'b00});
      if (mode == 2'b10) hit = (ba[33:2] == PMP_ADDR[i]);
      if (mode == 2'b11) begin
        // Region of 2^(k+3) bytes for k trailing ones
        k = 0;
        while (k < 32 && PMP_ADDR[i][k]) k++;
        hit = (ba >> (k + 3)) == ({PMP_ADDR[i], 2'b00} >> (k + 3));
      end
      if (hit) begin
        if (priv == PRIV_M && !PMP_CFG[i][7]) return 1'b0;
        return we ? !PMP_CFG[i][1] : !PMP_CFG[i][0];
      end
    end
    return priv != PRIV_M;
  endfunction

  always_comb begin
    pma_exp   = pma_expect(core_addr_i, core_dbg_i, core_misaligned_i, core_pushpop_i);
    pmp_exp   = pmp_denies(core_addr_i, core_we_i, core_dbg_i, priv_lvl_i);
    exp_fault = pma_exp[2] || pmp_exp;
    if (pma_exp[2]) exp_status = core_we_i ? MPU_WR_PMA_FAULT : MPU_RD_PMA_FAULT;
    else if (pmp_exp) exp_status = core_we_i ? MPU_WR_PMP_FAULT : MPU_RD_PMP_FAULT;
    else exp_status = MPU_OK;
  end

  // Area bias: main with NA4/TOR corners, I/O, debug module, unmapped
  task automatic new_request();
    case (lfsr_bits(2))
      0: begin
        case (lfsr_bits(2))
          0: core_addr_i = 32'h0000_1000 + lfsr_bits(3);
          1: core_addr_i = 32'h003F_FFF0 + lfsr_bits(5);
          default: core_addr_i = lfsr_bits(28);
        endcase
      end
      1: core_addr_i = PMA_IO_START + lfsr_bits(17);
      2: core_addr_i = DM_START + lfsr_bits(15);
      default: core_addr_i = 32'h4000_0000 + lfsr_bits(28);
    endcase
    core_dbg_i        = (core_addr_i >= DM_START) ? 1'(lfsr_bits(1)) : (lfsr_bits(4) == 0);
    core_we_i         = 1'(lfsr_bits(1));
    priv_lvl_i        = lfsr_bits(1) != 0 ? PRIV_M : PRIV_U;
    core_misaligned_i = (lfsr_bits(3) == 0);
    core_pushpop_i    = (lfsr_bits(3) == 0);
    core_wdata_i      = {issued[15:0], ~issued[15:0]};
    core_be_i         = 4'(lfsr_bits(4));
  endtask

  ////////////////////////////////////////////////////////////
  // Edge processes: observe on rise, drive on fall
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      m_state <= MPU_IDLE;
    end else begin
      if (bus_trans_valid_o && bus_trans_ready_i) begin
        due_q.push_back(cyc + 1 + int'(lfsr_bits(2)));
        bus_acc_cnt <= bus_acc_cnt + 1;
      end
      if (core_trans_valid_i && core_trans_ready_o) begin
        taken = 1'b1;
        core_acc_cnt <= core_acc_cnt + 1;
        if (exp_fault) fault_cnt <= fault_cnt + 1;
        else clean_acc_cnt <= clean_acc_cnt + 1;
      end
      if (core_resp_valid_o) resp_cnt <= resp_cnt + 1;
      case (m_state)
        MPU_IDLE: begin
          if (core_trans_valid_i && exp_fault) begin
            m_state  <= core_one_txn_pend_i ? MPU_RESP : MPU_WAIT;
            m_status <= exp_status;
          end
        end
        MPU_WAIT: if (core_one_txn_pend_i) m_state <= MPU_RESP;
        default: m_state <= MPU_IDLE;
      endcase
    end
    cyc = cyc + 1;
  end

  always @(negedge clk) begin
    if (rst_n) begin
      // In-order bus response when due
      bus_resp_valid_i = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        bus_resp_valid_i = 1'b1;
        bus_resp_rdata_i = {cyc[15:0], 16'h5A5A};
        bus_resp_err_i   = (lfsr_bits(3) == 0);
      end
      // Nothing left on the bus after this cycle
      core_one_txn_pend_i = (due_q.size() == 0);
      bus_trans_ready_i   = (lfsr_bits(2) != 0);
      if (taken || !core_trans_valid_i) begin
        taken = 1'b0;
        core_trans_valid_i = 1'b0;
        if (issued < N_REQ && lfsr_bits(3) != 0) begin
          new_request();
          core_trans_valid_i = 1'b1;
          issued++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !bus_trans_valid_o && !core_resp_valid_o)
    else begin $display("Fail %0t: valid output high during reset", $time); err_cnt++; end

  a_clean_fwd: assert property (@(posedge clk) disable iff (!rst_n)
    (m_state == MPU_IDLE && core_trans_valid_i && !exp_fault) |->
      (bus_trans_valid_o && bus_addr_o == core_addr_i && bus_we_o == core_we_i &&
       bus_wdata_o == core_wdata_i && bus_be_o == core_be_i &&
       bus_memtype_o == pma_exp[1:0]))
    else begin $display("Fail %0t: clean request %h not forwarded", $time, core_addr_i);
      err_cnt++; end

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    (m_state == MPU_IDLE && core_trans_valid_i && !exp_fault) |->
      core_trans_ready_o == bus_trans_ready_i)
    else begin $display("Fail %0t: core ready does not follow bus ready", $time); err_cnt++; end

  a_fault_taken: assert property (@(posedge clk) disable iff (!rst_n)
    (m_state == MPU_IDLE && core_trans_valid_i && exp_fault) |->
      core_trans_ready_o && !bus_trans_valid_o)
    else begin $display("Fail %0t: faulting request %h not consumed", $time, core_addr_i);
      err_cnt++; end

  a_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    (m_state != MPU_IDLE) |-> !core_trans_ready_o && !bus_trans_valid_o)
    else begin $display("Fail %0t: traffic not blocked behind a fault", $time); err_cnt++; end

  a_fault_resp: assert property (@(posedge clk) disable iff (!rst_n)
    (m_state == MPU_RESP) |-> core_resp_valid_o && core_resp_status_o == m_status)
    else begin $display("Fail %0t: fault response missing or status %s, expected %s",
      $time, core_resp_status_o.name(), m_status.name()); err_cnt++; end

  a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
    (m_state != MPU_RESP) |-> core_resp_valid_o == bus_resp_valid_i)
    else begin $display("Fail %0t: response strobe out of place", $time); err_cnt++; end

  a_pass_resp: assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_valid_i |-> core_resp_status_o == MPU_OK &&
      core_resp_rdata_o == bus_resp_rdata_i && core_resp_err_o == bus_resp_err_i)
    else begin $display("Fail %0t: bus response altered", $time); err_cnt++; end

  a_accept_count: assert property (@(posedge clk) disable iff (!rst_n)
    bus_acc_cnt == clean_acc_cnt)
    else begin $display("Fail %0t: %0d bus accepts for %0d clean requests", $time,
      bus_acc_cnt, clean_acc_cnt); err_cnt++; end

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr_q = 32'h8e17;
    {cyc, issued, err_cnt, fault_cnt, resp_cnt} = '0;
    {core_acc_cnt, clean_acc_cnt, bus_acc_cnt} = '0;
    taken = 1'b0;
    {core_trans_valid_i, core_we_i, core_dbg_i, core_misaligned_i, core_pushpop_i} = '0;
    core_addr_i = '0;
    core_wdata_i = '0;
    core_be_i = '0;
    core_one_txn_pend_i = 1'b1;
    csr_pmpcfg_i = PMP_CFG;
    csr_pmpaddr_i = PMP_ADDR;
    priv_lvl_i = PRIV_M;
    {bus_trans_ready_i, bus_resp_valid_i, bus_resp_err_i} = '0;
    bus_resp_rdata_i = '0;
    @(posedge rst_n);
    while (core_acc_cnt < N_REQ) @(posedge clk);
    // Drain outstanding bus and fault responses
    while (due_q.size() != 0 || m_state != MPU_IDLE) @(posedge clk);
    repeat (2) @(posedge clk);
    assert (resp_cnt == core_acc_cnt) else begin
      $display("Fail %0t: %0d responses for %0d requests", $time, resp_cnt, core_acc_cnt);
      err_cnt++;
    end
    $display("Requests %0d, faults %0d, bus accepts %0d, responses %0d, errors %0d",
             core_acc_cnt, fault_cnt, bus_acc_cnt, resp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog sized for 12 cycles per request plus reset
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: only %0d of %0d requests accepted in time", core_acc_cnt, N_REQ);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- flist.f
source/mpu_pkg.sv
source/mpu_req_if.sv
source/pma_check.sv
source/pmp_check.sv
source/mpu_gate.sv
source/lsu_mpu.sv
bench/tb_clk_gen.sv
bench/tb_lsu_mpu.sv

//--- Bender.yml
package:
  name: lsu_mpu

sources:
  - source/mpu_pkg.sv
  - source/mpu_req_if.sv
  - source/pma_check.sv
  - source/pmp_check.sv
  - source/mpu_gate.sv
  - source/lsu_mpu.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_lsu_mpu.sv
